// File: rtl/conv_accel_macros.svh
`ifndef CONV_ACCEL_MACROS_SVH
`define CONV_ACCEL_MACROS_SVH

// side of the square weight window, 3 works as well
`define WT_DIM 5

// weight and ifm element width
`define PIX_W 8

// memory data word and ofm value width
`define WORD_W 32

// byte address width on both memory channels
`define ADDR_W 32

`endif

// File: rtl/conv_accel_pkg.sv
`include "conv_accel_macros.svh"

package conv_accel_pkg;

  typedef logic [`ADDR_W-1:0] addr_t;
  typedef logic [`WORD_W-1:0] word_t;
  typedef logic signed [`PIX_W-1:0] pixel_t;

  // dimensions, depths and loop counts
  typedef logic [15:0] dim_t;

  // low address bits picking a byte out of a word
  typedef logic [1:0] byte_lane_t;

  typedef enum logic [2:0] {
    S_IDLE      = 3'd0,
    S_FETCH_OFM = 3'd1,
    S_FETCH_WT  = 3'd2,
    S_FETCH_IFM = 3'd3,
    S_COMPUTE   = 3'd4,
    S_WRITE_OFM = 3'd5,
    S_DONE      = 3'd6
  } seq_state_t;

  // job description written by the processor
  typedef struct packed {
    addr_t ifm_base;
    addr_t wt_base;
    addr_t ofm_base;
    dim_t  ifm_dim;
    dim_t  ifm_depth;
    dim_t  ofm_dim;
    dim_t  ofm_depth;
  } conv_cfg_t;

  // word set for a 4-byte ofm read, clear for a single byte
  typedef struct packed {
    addr_t addr;
    logic  word;
  } rd_req_t;

  typedef struct packed {
    addr_t addr;
    word_t data;
  } wr_req_t;

endpackage

// File: rtl/window_shift_reg.sv
`include "conv_accel_macros.svh"

module window_shift_reg (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       load,
  input  logic                       shift,
  input  conv_accel_pkg::byte_lane_t lane,
  input  conv_accel_pkg::word_t      rd_data,
  output conv_accel_pkg::pixel_t     head
);
  import conv_accel_pkg::*;

  localparam int WT_SIZE = `WT_DIM * `WT_DIM;

  pixel_t win [WT_SIZE];
  pixel_t lane_byte;

  // unaligned byte reads come back as the whole word
  assign lane_byte = pixel_t'(rd_data[lane * `PIX_W +: `PIX_W]);

  // entry 0 is the oldest element, new bytes enter at the tail
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < WT_SIZE; i++) begin
        win[i] <= '0;
      end
    end else if (load || shift) begin
      for (int i = 0; i < WT_SIZE - 1; i++) begin
        win[i] <= win[i + 1];
      end
      // on shift the head wraps around so the window is intact after compute
      win[WT_SIZE - 1] <= load ? lane_byte : win[0];
    end
  end

  assign head = win[0];

  // fetch and compute phases of the sequencer never overlap
  load_shift_excl: assert property (@(posedge clk) disable iff (reset)
    !(load && shift));

endmodule

// File: rtl/window_mac.sv
`include "conv_accel_macros.svh"

module window_mac (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   shift,
  input  logic                   acc_clear,
  input  logic                   psum_load,
  input  logic                   psum_clear,
  input  conv_accel_pkg::pixel_t wt,
  input  conv_accel_pkg::pixel_t pix,
  input  conv_accel_pkg::word_t  rd_data,
  output conv_accel_pkg::word_t  result
);
  import conv_accel_pkg::*;

  localparam int PROD_W = 2 * `PIX_W;

  logic signed [PROD_W-1:0] prod;
  word_t                    prod_ext;
  word_t                    acc;
  word_t                    psum;

  // both heads are signed so this is a signed multiply
  assign prod     = wt * pix;
  assign prod_ext = {{(`WORD_W - PROD_W){prod[PROD_W-1]}}, prod};

  // one product per compute cycle, wraps at the word width
  always_ff @(posedge clk) begin
    if (reset || acc_clear) begin
      acc <= '0;
    end else if (shift) begin
      acc <= acc + prod_ext;
    end
  end

  // result of earlier input channels, read back from the ofm
  always_ff @(posedge clk) begin
    if (reset || psum_clear) begin
      psum <= '0;
    end else if (psum_load) begin
      psum <= rd_data;
    end
  end

  assign result = psum + acc;

endmodule

// File: rtl/conv_sequencer.sv
`include "conv_accel_macros.svh"

module conv_sequencer (
  input  logic                       clk,
  input  logic                       reset,
  input  conv_accel_pkg::conv_cfg_t  cfg,
  input  logic                       start,
  output logic                       done,
  output logic                       idle,
  output conv_accel_pkg::rd_req_t    rd_req,
  output logic                       rd_req_valid,
  input  logic                       rd_req_ready,
  input  logic                       rd_data_valid,
  output logic                       rd_data_ready,
  output conv_accel_pkg::wr_req_t    wr_req,
  output logic                       wr_req_valid,
  input  logic                       wr_req_ready,
  output logic                       wt_load,
  output logic                       ifm_load,
  output logic                       shift,
  output logic                       acc_clear,
  output logic                       psum_load,
  output logic                       psum_clear,
  output conv_accel_pkg::byte_lane_t lane,
  input  conv_accel_pkg::word_t      result
);
  import conv_accel_pkg::*;

  localparam int WT_SIZE = `WT_DIM * `WT_DIM;

  seq_state_t state;
  seq_state_t state_next;
  conv_cfg_t  cfg_q;
  logic       prep;
  logic       req_pending;
  logic       done_q;

  // sizes derived once per job
  addr_t ifm_size;
  addr_t wt_volume;
  addr_t ofm_size;

  dim_t oc;
  dim_t ic;
  dim_t ofm_y;
  dim_t ofm_x;
  dim_t win_x;
  dim_t win_y;
  dim_t shift_cnt;
  addr_t ifm_idx;

  // base-relative offsets of the current channel and row
  addr_t wt_oc_off;
  addr_t wt_ic_off;
  addr_t ifm_ch_off;
  addr_t ifm_row_off;
  addr_t ofm_ch_off;
  addr_t ofm_row_off;

  addr_t win_idx;
  addr_t wt_addr;
  addr_t ifm_addr;
  addr_t ofm_addr;

  logic fetching;
  logic start_fire;
  logic req_fire;
  logic rd_fire;
  logic wr_fire;
  logic win_x_last;
  logic win_last;
  logic last_x;
  logic last_y;
  logic last_ic;
  logic last_oc;
  logic chan_end;

  assign idle       = state == S_IDLE;
  assign fetching   = state inside {S_FETCH_OFM, S_FETCH_WT, S_FETCH_IFM};
  assign start_fire = idle && start;
  assign req_fire   = rd_req_valid && rd_req_ready;
  assign rd_fire    = rd_data_valid && rd_data_ready;
  assign wr_fire    = wr_req_valid && wr_req_ready;

  assign win_x_last = win_x == dim_t'(`WT_DIM - 1);
  assign win_last   = win_x_last && (win_y == dim_t'(`WT_DIM - 1));
  assign last_x     = ofm_x == cfg_q.ofm_dim - 16'd1;
  assign last_y     = ofm_y == cfg_q.ofm_dim - 16'd1;
  assign last_ic    = ic == cfg_q.ifm_depth - 16'd1;
  assign last_oc    = oc == cfg_q.ofm_depth - 16'd1;
  assign chan_end   = last_x && last_y;

  always_comb begin
    state_next = state;
    case (state)
      S_IDLE:      if (start) state_next = S_FETCH_WT;
      // a fresh channel needs its weight set, otherwise the window is reused
      S_FETCH_OFM: if (rd_fire) state_next = (ofm_x == '0 && ofm_y == '0) ? S_FETCH_WT
                                                                         : S_FETCH_IFM;
      S_FETCH_WT:  if (rd_fire && win_last) state_next = S_FETCH_IFM;
      S_FETCH_IFM: if (rd_fire && win_last) state_next = S_COMPUTE;
      S_COMPUTE:   if (shift_cnt == dim_t'(WT_SIZE - 1)) state_next = S_WRITE_OFM;
      S_WRITE_OFM: begin
        if (wr_fire) begin
          if (chan_end && last_ic && last_oc) begin
            state_next = S_DONE;
          end else if (chan_end) begin
            state_next = last_ic ? S_FETCH_WT : S_FETCH_OFM;
          end else begin
            // nothing to accumulate onto in input channel 0
            state_next = (ic == '0) ? S_FETCH_IFM : S_FETCH_OFM;
          end
        end
      end
      S_DONE:      state_next = S_IDLE;
      default:     state_next = S_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= S_IDLE;
      prep  <= 1'b0;
    end else begin
      state <= state_next;
      prep  <= start_fire;
    end
  end

  always_ff @(posedge clk) begin
    if (start_fire) begin
      cfg_q <= cfg;
    end
    if (prep) begin
      ifm_size  <= addr_t'(cfg_q.ifm_dim) * addr_t'(cfg_q.ifm_dim);
      wt_volume <= addr_t'(cfg_q.ifm_depth) * addr_t'(WT_SIZE);
      ofm_size  <= addr_t'(cfg_q.ofm_dim) * addr_t'(cfg_q.ofm_dim);
    end
  end

  // only one request is in flight and the next one waits for its data beat
  always_ff @(posedge clk) begin
    if (reset || start_fire || rd_fire) begin
      req_pending <= 1'b0;
    end else if (req_fire) begin
      req_pending <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset || start_fire) begin
      done_q <= 1'b0;
    end else if (state == S_DONE) begin
      done_q <= 1'b1;
    end
  end

  assign done = done_q || (state == S_DONE);

  // channel, row and column loops advance once per written word
  always_ff @(posedge clk) begin
    if (reset || start_fire) begin
      oc          <= '0;
      ic          <= '0;
      ofm_y       <= '0;
      ofm_x       <= '0;
      wt_oc_off   <= '0;
      wt_ic_off   <= '0;
      ifm_ch_off  <= '0;
      ifm_row_off <= '0;
      ofm_ch_off  <= '0;
      ofm_row_off <= '0;
    end else if (wr_fire) begin
      if (!last_x) begin
        ofm_x <= ofm_x + 16'd1;
      end else begin
        ofm_x <= '0;
        if (!last_y) begin
          ofm_y       <= ofm_y + 16'd1;
          ofm_row_off <= ofm_row_off + addr_t'(cfg_q.ofm_dim);
          ifm_row_off <= ifm_row_off + addr_t'(cfg_q.ifm_dim);
        end else begin
          ofm_y       <= '0;
          ofm_row_off <= '0;
          ifm_row_off <= '0;
          if (!last_ic) begin
            ic         <= ic + 16'd1;
            ifm_ch_off <= ifm_ch_off + ifm_size;
            wt_ic_off  <= wt_ic_off + addr_t'(WT_SIZE);
          end else begin
            ic         <= '0;
            ifm_ch_off <= '0;
            wt_ic_off  <= '0;
            oc         <= oc + 16'd1;
            wt_oc_off  <= wt_oc_off + wt_volume;
            ofm_ch_off <= ofm_ch_off + ofm_size;
          end
        end
      end
    end
  end

  // the ifm index jumps to the next image row at the end of each window row
  always_ff @(posedge clk) begin
    if (reset || start_fire) begin
      win_x   <= '0;
      win_y   <= '0;
      ifm_idx <= '0;
    end else if (rd_fire && (state == S_FETCH_WT || state == S_FETCH_IFM)) begin
      win_x <= win_x_last ? '0 : win_x + 16'd1;
      if (win_x_last) begin
        win_y <= win_last ? '0 : win_y + 16'd1;
      end
      if (state == S_FETCH_IFM) begin
        if (win_last) begin
          ifm_idx <= '0;
        end else if (win_x_last) begin
          ifm_idx <= ifm_idx + addr_t'(cfg_q.ifm_dim) - addr_t'(`WT_DIM - 1);
        end else begin
          ifm_idx <= ifm_idx + 32'd1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset || !shift) begin
      shift_cnt <= '0;
    end else begin
      shift_cnt <= shift_cnt + 16'd1;
    end
  end

  assign win_idx  = addr_t'(win_y) * addr_t'(`WT_DIM) + addr_t'(win_x);
  assign wt_addr  = cfg_q.wt_base + wt_oc_off + wt_ic_off + win_idx;
  assign ifm_addr = cfg_q.ifm_base + ifm_ch_off + ifm_row_off + addr_t'(ofm_x) + ifm_idx;
  assign ofm_addr = cfg_q.ofm_base + ((ofm_ch_off + ofm_row_off + addr_t'(ofm_x)) << 2);

  always_comb begin
    rd_req.word = state == S_FETCH_OFM;
    if (state == S_FETCH_OFM) begin
      rd_req.addr = ofm_addr;
    end else if (state == S_FETCH_WT) begin
      rd_req.addr = wt_addr;
    end else begin
      rd_req.addr = ifm_addr;
    end
    wr_req.addr = ofm_addr;
    wr_req.data = result;
  end

  assign rd_req_valid  = fetching && !prep && !req_pending;
  assign rd_data_ready = fetching && !prep;
  assign wr_req_valid  = state == S_WRITE_OFM;
  assign lane          = rd_req.addr[1:0];

  assign wt_load    = rd_fire && (state == S_FETCH_WT);
  assign ifm_load   = rd_fire && (state == S_FETCH_IFM);
  assign psum_load  = rd_fire && (state == S_FETCH_OFM);
  assign shift      = state == S_COMPUTE;
  assign acc_clear  = (state_next == S_FETCH_IFM) && (state != S_FETCH_IFM);
  // zero partial sum for every pixel that belongs to input channel 0
  assign psum_clear = start_fire ||
                      (wr_fire && (chan_end ? last_ic : (ic == '0)));

  // a stalled read request keeps its address and size until the model takes it
  rd_req_hold: assert property (@(posedge clk) disable iff (reset)
    rd_req_valid && !rd_req_ready |=> rd_req_valid && $stable(rd_req));

  // a stalled write keeps its address and the finished sum until the model takes it
  wr_req_hold: assert property (@(posedge clk) disable iff (reset)
    wr_req_valid && !wr_req_ready |=> wr_req_valid && $stable(wr_req));

endmodule

// File: rtl/conv_accel_top.sv
module conv_accel_top (
  input  logic                       clk,
  input  logic                       reset,

  // processor side
  input  conv_accel_pkg::conv_cfg_t  cfg,
  input  logic                       start,
  output logic                       done,
  output logic                       idle,

  // read channel
  output conv_accel_pkg::rd_req_t    rd_req,
  output logic                       rd_req_valid,
  input  logic                       rd_req_ready,
  input  conv_accel_pkg::word_t      rd_data,
  input  logic                       rd_data_valid,
  output logic                       rd_data_ready,

  // write channel
  output conv_accel_pkg::wr_req_t    wr_req,
  output logic                       wr_req_valid,
  input  logic                       wr_req_ready
);
  import conv_accel_pkg::*;

  logic       wt_load;
  logic       ifm_load;
  logic       shift;
  logic       acc_clear;
  logic       psum_load;
  logic       psum_clear;
  byte_lane_t lane;
  pixel_t     wt_head;
  pixel_t     pix_head;
  word_t      result;

  conv_sequencer sequencer (
    .clk           (clk),
    .reset         (reset),
    .cfg           (cfg),
    .start         (start),
    .done          (done),
    .idle          (idle),
    .rd_req        (rd_req),
    .rd_req_valid  (rd_req_valid),
    .rd_req_ready  (rd_req_ready),
    .rd_data_valid (rd_data_valid),
    .rd_data_ready (rd_data_ready),
    .wr_req        (wr_req),
    .wr_req_valid  (wr_req_valid),
    .wr_req_ready  (wr_req_ready),
    .wt_load       (wt_load),
    .ifm_load      (ifm_load),
    .shift         (shift),
    .acc_clear     (acc_clear),
    .psum_load     (psum_load),
    .psum_clear    (psum_clear),
    .lane          (lane),
    .result        (result)
  );

  // weights and pixels rotate in lockstep during compute
  window_shift_reg wt_window (
    .clk     (clk),
    .reset   (reset),
    .load    (wt_load),
    .shift   (shift),
    .lane    (lane),
    .rd_data (rd_data),
    .head    (wt_head)
  );

  window_shift_reg ifm_window (
    .clk     (clk),
    .reset   (reset),
    .load    (ifm_load),
    .shift   (shift),
    .lane    (lane),
    .rd_data (rd_data),
    .head    (pix_head)
  );

  window_mac mac (
    .clk        (clk),
    .reset      (reset),
    .shift      (shift),
    .acc_clear  (acc_clear),
    .psum_load  (psum_load),
    .psum_clear (psum_clear),
    .wt         (wt_head),
    .pix        (pix_head),
    .rd_data    (rd_data),
    .result     (result)
  );

endmodule

// File: verification/ddr_model.sv
module ddr_model #(
  parameter int MEM_BYTES = 4096
) (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    stall_en,
  input  conv_accel_pkg::rd_req_t rd_req,
  input  logic                    rd_req_valid,
  output logic                    rd_req_ready,
  output conv_accel_pkg::word_t   rd_data,
  output logic                    rd_data_valid,
  input  logic                    rd_data_ready,
  input  conv_accel_pkg::wr_req_t wr_req,
  input  logic                    wr_req_valid,
  output logic                    wr_req_ready
);
  import conv_accel_pkg::*;

  logic [7:0] mem [MEM_BYTES];
  addr_t      rd_addr;
  logic       rd_pending;
  integer     seed;

  initial begin
    seed          = 32'h44534a53;
    rd_req_ready  = 1'b0;
    rd_data       = '0;
    rd_data_valid = 1'b0;
    rd_pending    = 1'b0;
    wr_req_ready  = 1'b0;
  end

  // index of the first byte of the aligned word holding address a
  function automatic int word_index(input addr_t a);
    return int'(a % MEM_BYTES) & ~3;
  endfunction

  // about one cycle in four is a stall when stalls are on
  function automatic logic draw_ready();
    if (!stall_en) begin
      return 1'b1;
    end
    return ($random(seed) & 3) != 0;
  endfunction

  // byte reads get the whole aligned word, little endian lanes
  always @(posedge clk) begin
    if (reset) begin
      rd_req_ready  <= 1'b0;
      rd_data_valid <= 1'b0;
      rd_pending    <= 1'b0;
    end else if (rd_req_valid && rd_req_ready) begin
      rd_addr      <= rd_req.addr;
      rd_pending   <= 1'b1;
      rd_req_ready <= 1'b0;
    end else if (rd_pending) begin
      if (draw_ready()) begin
        rd_data       <= {mem[word_index(rd_addr) + 3], mem[word_index(rd_addr) + 2],
                          mem[word_index(rd_addr) + 1], mem[word_index(rd_addr)]};
        rd_data_valid <= 1'b1;
        rd_pending    <= 1'b0;
      end
    end else if (rd_data_valid) begin
      if (rd_data_ready) begin
        rd_data_valid <= 1'b0;
        rd_req_ready  <= draw_ready();
      end
    end else begin
      rd_req_ready <= draw_ready();
    end
  end

  always @(posedge clk) begin
    if (reset) begin
      wr_req_ready <= 1'b0;
    end else if (wr_req_valid && wr_req_ready) begin
      for (int i = 0; i < 4; i++) begin
        mem[word_index(wr_req.addr) + i] <= wr_req.data[8*i +: 8];
      end
      wr_req_ready <= 1'b0;
    end else begin
      wr_req_ready <= draw_ready();
    end
  end

endmodule

// File: verification/conv_accel_tb.sv
`include "conv_accel_macros.svh"

module conv_accel_tb;
  import conv_accel_pkg::*;

  localparam int MEM_BYTES = 4096;
  localparam int NUM_TESTS = 5;
  localparam int TIMEOUT   = 200000;
  localparam int MAX_WORDS = 256;

  // unaligned ifm and weight bases so every byte lane gets used
  localparam addr_t IFM_BASE = 32'h0000_0103;
  localparam addr_t WT_BASE  = 32'h0000_0402;
  localparam addr_t OFM_BASE = 32'h0000_0800;

  typedef struct packed {
    dim_t        ifm_dim;
    dim_t        ifm_depth;
    dim_t        ofm_depth;
    logic        stall;
    logic [31:0] data_seed;
  } test_row_t;

  logic      clk;
  logic      reset;
  conv_cfg_t cfg;
  logic      start;
  logic      done;
  logic      idle;
  rd_req_t   rd_req;
  logic      rd_req_valid;
  logic      rd_req_ready;
  word_t     rd_data;
  logic      rd_data_valid;
  logic      rd_data_ready;
  wr_req_t   wr_req;
  logic      wr_req_valid;
  logic      wr_req_ready;
  logic      stall_en;

  test_row_t tests [NUM_TESTS];
  string     names [NUM_TESTS];
  int        golden [MAX_WORDS];
  integer    seed;
  int        pass_count;
  int        fail_count;
  int        req_errors;
  logic      timed_out;

  conv_accel_top UUT (
    .clk           (clk),
    .reset         (reset),
    .cfg           (cfg),
    .start         (start),
    .done          (done),
    .idle          (idle),
    .rd_req        (rd_req),
    .rd_req_valid  (rd_req_valid),
    .rd_req_ready  (rd_req_ready),
    .rd_data       (rd_data),
    .rd_data_valid (rd_data_valid),
    .rd_data_ready (rd_data_ready),
    .wr_req        (wr_req),
    .wr_req_valid  (wr_req_valid),
    .wr_req_ready  (wr_req_ready)
  );

  ddr_model #(.MEM_BYTES(MEM_BYTES)) ddr (
    .clk           (clk),
    .reset         (reset),
    .stall_en      (stall_en),
    .rd_req        (rd_req),
    .rd_req_valid  (rd_req_valid),
    .rd_req_ready  (rd_req_ready),
    .rd_data       (rd_data),
    .rd_data_valid (rd_data_valid),
    .rd_data_ready (rd_data_ready),
    .wr_req        (wr_req),
    .wr_req_valid  (wr_req_valid),
    .wr_req_ready  (wr_req_ready)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ofm words are read whole, weights and pixels one byte at a time
  always @(negedge clk) begin
    if (!reset && rd_req_valid && rd_req_ready) begin
      if (rd_req.word !== (rd_req.addr >= OFM_BASE)) begin
        $display("read request at %08h carries the wrong size flag %b",
                 rd_req.addr, rd_req.word);
        req_errors++;
      end
    end
  end

  task automatic set_row(input int i, input string name, input int dim, input int in_depth,
                         input int out_depth, input logic stall, input int data_seed);
    test_row_t row;
    row.ifm_dim   = dim_t'(dim);
    row.ifm_depth = dim_t'(in_depth);
    row.ofm_depth = dim_t'(out_depth);
    row.stall     = stall;
    row.data_seed = data_seed;
    tests[i] = row;
    names[i] = name;
  endtask

  task automatic fill_memory(input logic [31:0] data_seed);
    int r;
    seed = 32'h44534a53 + data_seed;
    for (int i = 0; i < MEM_BYTES; i++) begin
      r = $random(seed);
      ddr.mem[i] = r[7:0];
    end
  endtask

  function automatic byte mem_byte(input int a);
    return byte'(ddr.mem[a % MEM_BYTES]);
  endfunction

  // direct convolution straight from the memory layout
  task automatic compute_golden(input int dim, input int in_depth, input int out_depth);
    int ofm_dim;
    int acc;
    int pix_a;
    int wt_a;
    ofm_dim = dim - `WT_DIM + 1;
    for (int o = 0; o < out_depth; o++) begin
      for (int y = 0; y < ofm_dim; y++) begin
        for (int x = 0; x < ofm_dim; x++) begin
          acc = 0;
          for (int c = 0; c < in_depth; c++) begin
            for (int ky = 0; ky < `WT_DIM; ky++) begin
              for (int kx = 0; kx < `WT_DIM; kx++) begin
                pix_a = IFM_BASE + (c * dim + y + ky) * dim + x + kx;
                wt_a  = WT_BASE + ((o * in_depth + c) * `WT_DIM + ky) * `WT_DIM + kx;
                acc   = acc + mem_byte(pix_a) * mem_byte(wt_a);
              end
            end
          end
          golden[(o * ofm_dim + y) * ofm_dim + x] = acc;
        end
      end
    end
  endtask

  task automatic check_ofm(input string name, input int out_depth, input int ofm_dim,
                           inout int errors);
    int idx;
    int a;
    word_t actual;
    for (int o = 0; o < out_depth; o++) begin
      for (int y = 0; y < ofm_dim; y++) begin
        for (int x = 0; x < ofm_dim; x++) begin
          idx    = (o * ofm_dim + y) * ofm_dim + x;
          a      = OFM_BASE + 4 * idx;
          actual = {ddr.mem[a + 3], ddr.mem[a + 2], ddr.mem[a + 1], ddr.mem[a]};
          if (actual !== word_t'(golden[idx])) begin
            $display("[FAIL] %s ofm[%0d][%0d][%0d] expected %08h actual %08h",
                     name, o, y, x, word_t'(golden[idx]), actual);
            errors++;
          end
        end
      end
    end
  endtask

  task automatic finish_test(input string name, input int errors);
    if (errors == 0) begin
      pass_count++;
      $display("test %s: passed", name);
    end else begin
      fail_count++;
      $display("test %s: failed with %0d errors", name, errors);
    end
  endtask

  task automatic check_reset_state();
    int errors;
    errors = 0;
    @(negedge clk);
    if (idle !== 1'b1) begin
      $display("[FAIL] reset_state idle expected 1 actual %b", idle);
      errors++;
    end
    if (done !== 1'b0) begin
      $display("[FAIL] reset_state done expected 0 actual %b", done);
      errors++;
    end
    if ({rd_req_valid, rd_data_ready, wr_req_valid} !== 3'b000) begin
      $display("[FAIL] reset_state valid/ready expected 000 actual %b",
               {rd_req_valid, rd_data_ready, wr_req_valid});
      errors++;
    end
    finish_test("reset_state", errors);
  endtask

  task automatic run_test(input int t);
    test_row_t row;
    conv_cfg_t job;
    int        ofm_dim;
    int        errors;
    int        cycles;
    row        = tests[t];
    ofm_dim    = int'(row.ifm_dim) - `WT_DIM + 1;
    errors     = 0;
    req_errors = 0;
    fill_memory(row.data_seed);
    compute_golden(row.ifm_dim, row.ifm_depth, row.ofm_depth);

    // done of the previous job holds until the next start
    if (t > 0) begin
      repeat (3) begin
        @(negedge clk);
        if (done !== 1'b1) begin
          $display("[FAIL] %s done before start expected 1 actual %b", names[t], done);
          errors++;
        end
      end
    end

    job.ifm_base  = IFM_BASE;
    job.wt_base   = WT_BASE;
    job.ofm_base  = OFM_BASE;
    job.ifm_dim   = row.ifm_dim;
    job.ifm_depth = row.ifm_depth;
    job.ofm_dim   = dim_t'(ofm_dim);
    job.ofm_depth = row.ofm_depth;
    @(posedge clk);
    cfg      <= job;
    stall_en <= row.stall;
    start    <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    @(negedge clk);
    if (done !== 1'b0) begin
      $display("[FAIL] %s done after start expected 0 actual %b", names[t], done);
      errors++;
    end

    cycles = 0;
    while (done !== 1'b1 && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (done !== 1'b1) begin
      $display("test %s: done never came within %0d cycles, the accelerator is stuck",
               names[t], TIMEOUT);
      fail_count++;
      timed_out = 1'b1;
    end else begin
      check_ofm(names[t], row.ofm_depth, ofm_dim, errors);
      errors = errors + req_errors;
      finish_test(names[t], errors);
    end
  endtask

  initial begin
    reset      = 1'b1;
    start      = 1'b0;
    cfg        = '0;
    stall_en   = 1'b0;
    pass_count = 0;
    fail_count = 0;
    req_errors = 0;
    timed_out  = 1'b0;
    seed       = 32'h44534a53;

    // name, ifm_dim, ifm_depth, ofm_depth, stall, data seed
    set_row(0, "single_ch", 7, 1, 1, 1'b0, 0);
    set_row(1, "multi_ic",  7, 3, 1, 1'b0, 1);
    set_row(2, "multi_oc",  8, 2, 3, 1'b0, 2);
    set_row(3, "stalled",   7, 2, 2, 1'b1, 3);
    set_row(4, "rerun",     6, 1, 2, 1'b0, 4);

    repeat (5) @(posedge clk);
    reset <= 1'b0;
    check_reset_state();

    for (int t = 0; t < NUM_TESTS && !timed_out; t++) begin
      run_test(t);
    end

    $display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: conv_accel.f
+incdir+rtl
rtl/conv_accel_pkg.sv
rtl/window_shift_reg.sv
rtl/window_mac.sv
rtl/conv_sequencer.sv
rtl/conv_accel_top.sv
verification/ddr_model.sv
verification/conv_accel_tb.sv
